// File: Makefile
VERILATOR  ?= verilator
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing
TOP        := tb_fp_ss
FILELIST   := compile.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := *** TEST PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qF "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: compile.f
src/fp_ss_pkg.sv
src/fp_ss_if.sv
src/fp_spill_reg.sv
src/fp_decode.sv
src/fp_regfile.sv
src/fp_issue.sv
src/fp_exec.sv
src/fp_writeback.sv
src/fp_ss_top.sv
sim/tb_fp_ss.sv

// File: sim/fp_ss_testdata.txt
// instr    arga     rsp data     err   (one request per line, id = line index)
// rsp = 1 means a response with this data and error bit is expected
F00000D3 3F800000 0 00000000 0
E0008053 00000000 1 3F800000 0
F0000153 C0000000 0 00000000 0
F00001D3 7F800001 0 00000000 0
F0000253 00000000 0 00000000 0
F00002D3 80000000 0 00000000 0
F0000353 FFC12345 0 00000000 0
202083D3 00000000 0 00000000 0
E0038053 00000000 1 BF800000 0
20211453 00000000 0 00000000 0
201124D3 00000000 0 00000000 0
E0040053 00000000 1 40000000 0
E0048053 00000000 1 C0000000 0
28308553 00000000 0 00000000 0
286195D3 00000000 0 00000000 0
28520653 00000000 0 00000000 0
28208753 00000000 0 00000000 0
E0050053 00000000 1 3F800000 0
E0058053 00000000 1 7FC00000 0
E0060053 00000000 1 80000000 0
E0070053 00000000 1 C0000000 0
A0522053 00000000 1 00000001 0
A0429053 00000000 1 00000000 0
A0428053 00000000 1 00000001 0
A0111053 00000000 1 00000001 0
A031A053 00000000 1 00000000 0
A0208053 00000000 1 00000000 0
FFFFFFFF 00000000 1 00000000 1
00000013 00000000 1 00000000 1

// File: sim/tb_fp_ss.sv
/* Testbench for the FP issue subsystem
   Streams test vectors into the request channel and checks responses in order */
`timescale 1ns/1ps
`default_nettype none

module tb_fp_ss;

  localparam int NUM_VEC        = 29;
  localparam int COLS           = 5;
  localparam int DRAIN_CYCLES   = 20;
  localparam int TIMEOUT_CYCLES = 40 * NUM_VEC + DRAIN_CYCLES;

  logic        clk_i;
  logic        arst_n_i;
  logic [4:0]  acc_qid_i;
  logic [31:0] acc_qdata_op_i;
  logic [31:0] acc_qdata_arga_i;
  logic        acc_qvalid_i;
  logic        acc_qready_o;
  logic [4:0]  acc_pid_o;
  logic [31:0] acc_pdata_o;
  logic        acc_perror_o;
  logic        acc_pvalid_o;
  logic        acc_pready_i;

  // Columns are instr, arga, response flag, expected data and expected error
  logic [31:0] vec_mem [NUM_VEC*COLS];
  int          exp_q[$];
  int          errors;
  int          rsp_count;
  int          seed;

  fp_ss_top fp_ss_top_i (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .acc_qid_i        (acc_qid_i),
    .acc_qdata_op_i   (acc_qdata_op_i),
    .acc_qdata_arga_i (acc_qdata_arga_i),
    .acc_qvalid_i     (acc_qvalid_i),
    .acc_qready_o     (acc_qready_o),
    .acc_pid_o        (acc_pid_o),
    .acc_pdata_o      (acc_pdata_o),
    .acc_perror_o     (acc_perror_o),
    .acc_pvalid_o     (acc_pvalid_o),
    .acc_pready_i     (acc_pready_i)
  );

  always #2 clk_i = ~clk_i;

  // ----------------------------------------------------------
  // Request side sending one vector per transfer back to back
  // ----------------------------------------------------------
  task automatic drive_requests();
    for (int i = 0; i < NUM_VEC; i++) begin
      acc_qvalid_i     = 1'b1;
      acc_qid_i        = i[4:0];
      acc_qdata_op_i   = vec_mem[i*COLS];
      acc_qdata_arga_i = vec_mem[i*COLS+1];
      // qready comes from flops, so it holds until the next rising edge
      while (!acc_qready_o) @(negedge clk_i);
      @(negedge clk_i);
    end
    acc_qvalid_i = 1'b0;
  endtask

  // ----------------------------------------------------------
  // Response side under random back-pressure
  // ----------------------------------------------------------
  task automatic collect_responses();
    int          idx;
    logic [31:0] rnd;
    logic [31:0] exp_data;
    logic        exp_err;
    while (exp_q.size() > 0) begin
      @(negedge clk_i);
      rnd          = $random(seed);
      acc_pready_i = rnd[1:0] != 2'b00;
      if (acc_pvalid_o && acc_pready_i) begin
        idx      = exp_q.pop_front();
        exp_data = vec_mem[idx*COLS+3];
        exp_err  = vec_mem[idx*COLS+4][0];
        rsp_count++;
        if (acc_pid_o !== idx[4:0]) begin
          $display("FAILED vector %0d: acc_pid_o = 0x%02h, expected 0x%02h",
                   idx, acc_pid_o, idx[4:0]);
          errors++;
        end
        if (acc_pdata_o !== exp_data) begin
          $display("FAILED vector %0d: acc_pdata_o = 0x%08h, expected 0x%08h",
                   idx, acc_pdata_o, exp_data);
          errors++;
        end
        if (acc_perror_o !== exp_err) begin
          $display("FAILED vector %0d: acc_perror_o = 0x%01h, expected 0x%01h",
                   idx, acc_perror_o, exp_err);
          errors++;
        end
      end
    end
  endtask

  // Moves and register writes must leave nothing behind on the bus
  task automatic check_drain();
    acc_pready_i = 1'b1;
    repeat (DRAIN_CYCLES) begin
      @(negedge clk_i);
      if (acc_pvalid_o) begin
        $display("Unexpected extra response with id 0x%02h", acc_pid_o);
        errors++;
      end
    end
  endtask

  initial begin
    clk_i            = 1'b0;
    arst_n_i         = 1'b0;
    acc_qid_i        = '0;
    acc_qdata_op_i   = '0;
    acc_qdata_arga_i = '0;
    acc_qvalid_i     = 1'b0;
    acc_pready_i     = 1'b0;
    errors           = 0;
    rsp_count        = 0;
    seed             = 32'hc4b6887f;

    $readmemh("sim/fp_ss_testdata.txt", vec_mem);
    for (int i = 0; i < NUM_VEC; i++) begin
      if (vec_mem[i*COLS+2][0]) exp_q.push_back(i);
    end
    if (exp_q.size() == 0) begin
      $display("Test data holds no expected responses, file not loaded");
      errors++;
    end

    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;
    @(negedge clk_i);
    if (acc_pvalid_o !== 1'b0) begin
      $display("FAILED after reset: acc_pvalid_o = 0x%01h, expected 0x0", acc_pvalid_o);
      errors++;
    end
    if (acc_qready_o !== 1'b1) begin
      $display("FAILED after reset: acc_qready_o = 0x%01h, expected 0x1", acc_qready_o);
      errors++;
    end

    fork
      drive_requests();
      collect_responses();
    join
    check_drain();

    $display("Summary: %0d vectors, %0d responses checked, %0d errors",
             NUM_VEC, rsp_count, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk_i);
    $display("Timeout after %0d cycles, %0d responses still missing",
             TIMEOUT_CYCLES, exp_q.size());
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

// File: src/fp_decode.sv
/* Instruction decoder
   Maps an instruction word onto an operation and its register usage */
`timescale 1ns/1ps
`default_nettype none

module fp_decode (
  input  fp_ss_pkg::acc_req_t req_i,
  output fp_ss_pkg::dec_t     dec_o
);

  always_comb begin
    dec_o     = '0;
    dec_o.op  = fp_ss_pkg::NONE;
    dec_o.rd  = req_i.op[11:7];
    dec_o.rs1 = req_i.op[19:15];
    dec_o.rs2 = req_i.op[24:20];

    casez (req_i.op)
      fp_ss_pkg::FSGNJ_S:  dec_o.op = fp_ss_pkg::SGNJ;
      fp_ss_pkg::FSGNJN_S: dec_o.op = fp_ss_pkg::SGNJN;
      fp_ss_pkg::FSGNJX_S: dec_o.op = fp_ss_pkg::SGNJX;
      fp_ss_pkg::FMIN_S:   dec_o.op = fp_ss_pkg::MIN;
      fp_ss_pkg::FMAX_S:   dec_o.op = fp_ss_pkg::MAX;
      fp_ss_pkg::FEQ_S:    dec_o.op = fp_ss_pkg::FEQ;
      fp_ss_pkg::FLT_S:    dec_o.op = fp_ss_pkg::FLT;
      fp_ss_pkg::FLE_S:    dec_o.op = fp_ss_pkg::FLE;
      fp_ss_pkg::FMV_X_W:  dec_o.op = fp_ss_pkg::PASS;
      // Register write straight from arga, bypasses the pipe
      fp_ss_pkg::FMV_W_X:  dec_o.is_move = 1'b1;
      default:             dec_o.illegal = 1'b1;
    endcase

    // Register usage follows from the operation class
    dec_o.reads_rs1  = dec_o.op != fp_ss_pkg::NONE;
    dec_o.reads_rs2  = dec_o.op != fp_ss_pkg::NONE && dec_o.op != fp_ss_pkg::PASS;
    dec_o.writes_fpr = dec_o.is_move ||
                       dec_o.op inside {fp_ss_pkg::SGNJ, fp_ss_pkg::SGNJN,
                                        fp_ss_pkg::SGNJX, fp_ss_pkg::MIN,
                                        fp_ss_pkg::MAX};
    dec_o.to_bus     = dec_o.illegal ||
                       dec_o.op inside {fp_ss_pkg::FEQ, fp_ss_pkg::FLT,
                                        fp_ss_pkg::FLE, fp_ss_pkg::PASS};
  end

endmodule

`default_nettype wire

// File: src/fp_exec.sv
/* Execution pipe
   Operand register stage, then sign injection, min/max and compares */
`timescale 1ns/1ps
`default_nettype none

module fp_exec (
  input  logic        clk_i,
  input  logic        arst_n_i,
  fp_issue_if.slave   issue,
  fp_result_if.master result
);

  fp_ss_pkg::fp_op_e          s1_op_q;
  logic [fp_ss_pkg::FLEN-1:0] s1_opa_q;
  logic [fp_ss_pkg::FLEN-1:0] s1_opb_q;
  fp_ss_pkg::exec_tag_t       s1_tag_q;
  logic                       s1_valid_q;
  logic [fp_ss_pkg::FLEN-1:0] s2_data_q;
  fp_ss_pkg::exec_tag_t       s2_tag_q;
  logic                       s2_valid_q;
  logic                       advance;
  logic                       a_nan;
  logic                       b_nan;
  logic                       zeros;
  logic                       a_lt_b;
  logic                       is_eq;
  logic [fp_ss_pkg::FLEN-1:0] res;

  // Whole pipe stalls while the result is held
  assign advance     = !s2_valid_q || result.ready;
  assign issue.ready = advance;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
    end else if (advance) begin
      s1_valid_q <= issue.valid;
      s2_valid_q <= s1_valid_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (advance) begin
      s1_op_q   <= issue.op;
      s1_opa_q  <= issue.opa;
      s1_opb_q  <= issue.opb;
      s1_tag_q  <= issue.tag;
      s2_data_q <= res;
      s2_tag_q  <= s1_tag_q;
    end
  end

  // ----------------------------------------------------------
  // Operand classification
  // ----------------------------------------------------------
  assign a_nan = (&s1_opa_q[30:23]) && (|s1_opa_q[22:0]);
  assign b_nan = (&s1_opb_q[30:23]) && (|s1_opb_q[22:0]);
  assign zeros = (s1_opa_q[30:0] == '0) && (s1_opb_q[30:0] == '0);
  assign is_eq = !a_nan && !b_nan && (s1_opa_q == s1_opb_q || zeros);

  // Total order on sign/magnitude, -0 sits below +0
  always_comb begin
    if (s1_opa_q[31] != s1_opb_q[31]) a_lt_b = s1_opa_q[31];
    else if (s1_opa_q[31]) a_lt_b = s1_opa_q[30:0] > s1_opb_q[30:0];
    else a_lt_b = s1_opa_q[30:0] < s1_opb_q[30:0];
  end

  always_comb begin
    res = '0;
    case (s1_op_q)
      fp_ss_pkg::SGNJ:  res = {s1_opb_q[31], s1_opa_q[30:0]};
      fp_ss_pkg::SGNJN: res = {~s1_opb_q[31], s1_opa_q[30:0]};
      fp_ss_pkg::SGNJX: res = {s1_opa_q[31] ^ s1_opb_q[31], s1_opa_q[30:0]};
      fp_ss_pkg::MIN, fp_ss_pkg::MAX: begin
        if (a_nan && b_nan) res = fp_ss_pkg::CANON_NAN;
        else if (a_nan) res = s1_opb_q;
        else if (b_nan) res = s1_opa_q;
        else if (a_lt_b ^ (s1_op_q == fp_ss_pkg::MAX)) res = s1_opa_q;
        else res = s1_opb_q;
      end
      // Compares see zeros of either sign as equal
      fp_ss_pkg::FEQ:   res[0] = is_eq;
      fp_ss_pkg::FLT:   res[0] = !a_nan && !b_nan && a_lt_b && !zeros;
      fp_ss_pkg::FLE:   res[0] = !a_nan && !b_nan && (a_lt_b || is_eq);
      fp_ss_pkg::PASS:  res = s1_opa_q;
      default:          res = '0;
    endcase
  end

  assign result.valid = s2_valid_q;
  assign result.data  = s2_data_q;
  assign result.tag   = s2_tag_q;

endmodule

`default_nettype wire

// File: src/fp_issue.sv
/* Issue stage
   Scoreboard of pending destinations, operand read and dispatch to the
   execution pipe or to a direct register move */
`timescale 1ns/1ps
`default_nettype none

module fp_issue (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  input  logic                          valid_i,
  output logic                          ready_o,
  input  fp_ss_pkg::dec_t               dec_i,
  input  logic [fp_ss_pkg::ID_W-1:0]    id_i,
  input  logic [fp_ss_pkg::FLEN-1:0]    arga_i,
  output logic [fp_ss_pkg::REG_AW-1:0]  raddr_a_o,
  output logic [fp_ss_pkg::REG_AW-1:0]  raddr_b_o,
  input  logic [fp_ss_pkg::FLEN-1:0]    rdata_a_i,
  input  logic [fp_ss_pkg::FLEN-1:0]    rdata_b_i,
  fp_issue_if.master                    issue,
  output logic                          mv_valid_o,
  output logic [fp_ss_pkg::REG_AW-1:0]  mv_rd_o,
  output logic [fp_ss_pkg::FLEN-1:0]    mv_data_o,
  input  logic                          wb_we_i,
  input  logic [fp_ss_pkg::REG_AW-1:0]  wb_waddr_i
);

  logic [fp_ss_pkg::NUM_FPR-1:0] sb_d;
  logic [fp_ss_pkg::NUM_FPR-1:0] sb_q;
  logic                          src_busy;
  logic                          dst_busy;
  logic                          dispatch;

  // ----------------------------------------------------------
  // Hazard checks
  // ----------------------------------------------------------
  assign src_busy = (dec_i.reads_rs1 && sb_q[dec_i.rs1]) ||
                    (dec_i.reads_rs2 && sb_q[dec_i.rs2]);
  // A pending write to rd blocks both moves and pipe ops
  assign dst_busy = dec_i.writes_fpr && sb_q[dec_i.rd];

  // A move goes straight to the write port and is taken at once
  assign mv_valid_o = valid_i && dec_i.is_move && !dst_busy;
  assign mv_rd_o    = dec_i.rd;
  assign mv_data_o  = arga_i;

  assign raddr_a_o   = dec_i.rs1;
  assign raddr_b_o   = dec_i.rs2;
  assign issue.valid = valid_i && !dec_i.is_move && !src_busy && !dst_busy;
  assign issue.op    = dec_i.op;
  assign issue.opa   = rdata_a_i;
  assign issue.opb   = rdata_b_i;
  assign issue.tag   = '{id: id_i, rd: dec_i.rd, to_bus: dec_i.to_bus, error: dec_i.illegal};

  assign dispatch = issue.valid && issue.ready;
  assign ready_o  = mv_valid_o || dispatch;

  // ----------------------------------------------------------
  // Scoreboard
  // ----------------------------------------------------------
  always_comb begin
    sb_d = sb_q;
    if (wb_we_i) sb_d[wb_waddr_i] = 1'b0;
    // Set after clear so a new claim wins
    if (dispatch && dec_i.writes_fpr) sb_d[dec_i.rd] = 1'b1;
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sb_q <= '0;
    end else begin
      sb_q <= sb_d;
    end
  end

  // Pipe results only ever retire registers that were claimed here
  wb_claimed: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    wb_we_i && !mv_valid_o |-> sb_q[wb_waddr_i]);

endmodule

`default_nettype wire

// File: src/fp_regfile.sv
/* FP register file, 32 x 32 bit, two read ports and one write port */
`timescale 1ns/1ps
`default_nettype none

module fp_regfile (
  input  logic                          clk_i,
  input  logic [fp_ss_pkg::REG_AW-1:0]  raddr_a_i,
  input  logic [fp_ss_pkg::REG_AW-1:0]  raddr_b_i,
  output logic [fp_ss_pkg::FLEN-1:0]    rdata_a_o,
  output logic [fp_ss_pkg::FLEN-1:0]    rdata_b_o,
  input  logic                          we_i,
  input  logic [fp_ss_pkg::REG_AW-1:0]  waddr_i,
  input  logic [fp_ss_pkg::FLEN-1:0]    wdata_i
);

  logic [fp_ss_pkg::FLEN-1:0] mem_q [fp_ss_pkg::NUM_FPR];

  always_ff @(posedge clk_i) begin
    if (we_i) mem_q[waddr_i] <= wdata_i;
  end

  assign rdata_a_o = mem_q[raddr_a_i];
  assign rdata_b_o = mem_q[raddr_b_i];

  wdata_known: assert property (@(posedge clk_i) we_i |-> !$isunknown(wdata_i));

endmodule

`default_nettype wire

// File: src/fp_spill_reg.sv
/* Spill register
   Two-entry valid/ready buffer that cuts the ready path */
`timescale 1ns/1ps
`default_nettype none

module fp_spill_reg #(
  parameter type T = logic [31:0]
) (
  input  logic clk_i,
  input  logic arst_n_i,
  input  logic valid_i,
  output logic ready_o,
  input  T     data_i,
  output logic valid_o,
  input  logic ready_i,
  output T     data_o
);

  T     a_data_q;
  T     b_data_q;
  logic a_full_q;
  logic b_full_q;
  logic a_fill;
  logic a_drain;
  logic b_fill;
  logic b_drain;

  // A takes new input, B catches A when the output stalls
  assign a_fill  = valid_i && ready_o;
  assign a_drain = a_full_q && !b_full_q;
  assign b_fill  = a_drain && !ready_i;
  assign b_drain = b_full_q && ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      a_full_q <= a_fill || (a_full_q && !a_drain);
      b_full_q <= b_fill || (b_full_q && !b_drain);
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fill) a_data_q <= data_i;
    if (b_fill) b_data_q <= a_data_q;
  end

  // B always holds the older entry
  assign ready_o = !a_full_q || !b_full_q;
  assign valid_o = a_full_q || b_full_q;
  assign data_o  = b_full_q ? b_data_q : a_data_q;

  a_out_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    valid_o && !ready_i |=> valid_o && $stable(data_o));

endmodule

`default_nettype wire

// File: src/fp_ss_if.sv
/* Issue and result channels between the issue stage, the execution
   pipe and the writeback, both valid/ready */
`timescale 1ns/1ps
`default_nettype none

interface fp_issue_if;
  logic                        valid;
  logic                        ready;
  fp_ss_pkg::fp_op_e           op;
  logic [fp_ss_pkg::FLEN-1:0]  opa;
  logic [fp_ss_pkg::FLEN-1:0]  opb;
  fp_ss_pkg::exec_tag_t        tag;

  modport master (output valid, op, opa, opb, tag, input ready);
  modport slave  (input valid, op, opa, opb, tag, output ready);
endinterface

interface fp_result_if;
  logic                        valid;
  logic                        ready;
  logic [fp_ss_pkg::FLEN-1:0]  data;
  fp_ss_pkg::exec_tag_t        tag;

  modport master (output valid, data, tag, input ready);
  modport slave  (input valid, data, tag, output ready);
endinterface

`default_nettype wire

// File: src/fp_ss_pkg.sv
/* FP subsystem package
   Widths, opcode match patterns and the types shared by the issue path */
`default_nettype none

package fp_ss_pkg;

  localparam int unsigned FLEN    = 32;
  localparam int unsigned REG_AW  = 5;
  localparam int unsigned NUM_FPR = 32;
  localparam int unsigned ID_W    = 5;

  localparam logic [FLEN-1:0] CANON_NAN = 32'h7fc00000;

  // ----------------------------------------------------------
  // Instruction match patterns (funct7 rs2 rs1 funct3 rd opcode)
  // ----------------------------------------------------------
  localparam logic [31:0] FSGNJ_S  = 32'b0010000_?????_?????_000_?????_1010011;
  localparam logic [31:0] FSGNJN_S = 32'b0010000_?????_?????_001_?????_1010011;
  localparam logic [31:0] FSGNJX_S = 32'b0010000_?????_?????_010_?????_1010011;
  localparam logic [31:0] FMIN_S   = 32'b0010100_?????_?????_000_?????_1010011;
  localparam logic [31:0] FMAX_S   = 32'b0010100_?????_?????_001_?????_1010011;
  localparam logic [31:0] FEQ_S    = 32'b1010000_?????_?????_010_?????_1010011;
  localparam logic [31:0] FLT_S    = 32'b1010000_?????_?????_001_?????_1010011;
  localparam logic [31:0] FLE_S    = 32'b1010000_?????_?????_000_?????_1010011;
  localparam logic [31:0] FMV_X_W  = 32'b1110000_00000_?????_000_?????_1010011;
  localparam logic [31:0] FMV_W_X  = 32'b1111000_00000_?????_000_?????_1010011;

  typedef enum logic [3:0] {
    SGNJ, SGNJN, SGNJX, MIN, MAX, FEQ, FLT, FLE, PASS, NONE
  } fp_op_e;

  typedef struct packed {
    logic [ID_W-1:0] id;
    logic [31:0]     op;
    logic [31:0]     arga;
  } acc_req_t;

  typedef struct packed {
    logic [ID_W-1:0] id;
    logic [31:0]     data;
    logic            error;
  } acc_rsp_t;

  typedef struct packed {
    fp_op_e            op;
    logic [REG_AW-1:0] rs1;
    logic [REG_AW-1:0] rs2;
    logic [REG_AW-1:0] rd;
    logic              reads_rs1;
    logic              reads_rs2;
    logic              writes_fpr;
    logic              to_bus;     // result returns on the response channel
    logic              is_move;
    logic              illegal;
  } dec_t;

  // Travels alongside each operation through the execution pipe
  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [REG_AW-1:0] rd;
    logic              to_bus;
    logic              error;
  } exec_tag_t;

endpackage

`default_nettype wire

// File: src/fp_ss_top.sv
/* FP issue subsystem top
   Request buffer, decode, issue, register file, pipe and response buffer */
`timescale 1ns/1ps
`default_nettype none

module fp_ss_top (
  input  logic                         clk_i,
  input  logic                         arst_n_i,
  input  logic [fp_ss_pkg::ID_W-1:0]   acc_qid_i,
  input  logic [31:0]                  acc_qdata_op_i,
  input  logic [31:0]                  acc_qdata_arga_i,
  input  logic                         acc_qvalid_i,
  output logic                         acc_qready_o,
  output logic [fp_ss_pkg::ID_W-1:0]   acc_pid_o,
  output logic [31:0]                  acc_pdata_o,
  output logic                         acc_perror_o,
  output logic                         acc_pvalid_o,
  input  logic                         acc_pready_i
);

  fp_ss_pkg::acc_req_t                req_in;
  fp_ss_pkg::acc_req_t                req_q;
  logic                               req_valid;
  logic                               req_ready;
  fp_ss_pkg::dec_t                    dec;
  logic [fp_ss_pkg::REG_AW-1:0]       raddr_a;
  logic [fp_ss_pkg::REG_AW-1:0]       raddr_b;
  logic [fp_ss_pkg::FLEN-1:0]         rdata_a;
  logic [fp_ss_pkg::FLEN-1:0]         rdata_b;
  logic                               mv_valid;
  logic [fp_ss_pkg::REG_AW-1:0]       mv_rd;
  logic [fp_ss_pkg::FLEN-1:0]         mv_data;
  logic                               we;
  logic [fp_ss_pkg::REG_AW-1:0]       waddr;
  logic [fp_ss_pkg::FLEN-1:0]         wdata;
  fp_ss_pkg::acc_rsp_t                rsp;
  fp_ss_pkg::acc_rsp_t                rsp_q;
  logic                               rsp_valid;
  logic                               rsp_ready;

  fp_issue_if  issue_bus ();
  fp_result_if result_bus ();

  assign req_in       = '{id: acc_qid_i, op: acc_qdata_op_i, arga: acc_qdata_arga_i};
  assign acc_pid_o    = rsp_q.id;
  assign acc_pdata_o  = rsp_q.data;
  assign acc_perror_o = rsp_q.error;

  // ----------------------------------------------------------
  // Request side
  // ----------------------------------------------------------
  fp_spill_reg #(.T(fp_ss_pkg::acc_req_t)) req_spill_i (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .valid_i  (acc_qvalid_i),
    .ready_o  (acc_qready_o),
    .data_i   (req_in),
    .valid_o  (req_valid),
    .ready_i  (req_ready),
    .data_o   (req_q)
  );

  fp_decode fp_decode_i (
    .req_i (req_q),
    .dec_o (dec)
  );

  // ----------------------------------------------------------
  // Issue, registers and execution
  // ----------------------------------------------------------
  fp_issue fp_issue_i (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .valid_i    (req_valid),
    .ready_o    (req_ready),
    .dec_i      (dec),
    .id_i       (req_q.id),
    .arga_i     (req_q.arga),
    .raddr_a_o  (raddr_a),
    .raddr_b_o  (raddr_b),
    .rdata_a_i  (rdata_a),
    .rdata_b_i  (rdata_b),
    .issue      (issue_bus),
    .mv_valid_o (mv_valid),
    .mv_rd_o    (mv_rd),
    .mv_data_o  (mv_data),
    .wb_we_i    (we),
    .wb_waddr_i (waddr)
  );

  fp_regfile fp_regfile_i (
    .clk_i     (clk_i),
    .raddr_a_i (raddr_a),
    .raddr_b_i (raddr_b),
    .rdata_a_o (rdata_a),
    .rdata_b_o (rdata_b),
    .we_i      (we),
    .waddr_i   (waddr),
    .wdata_i   (wdata)
  );

  fp_exec fp_exec_i (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .issue    (issue_bus),
    .result   (result_bus)
  );

  // ----------------------------------------------------------
  // Response side
  // ----------------------------------------------------------
  fp_writeback fp_writeback_i (
    .mv_valid_i  (mv_valid),
    .mv_rd_i     (mv_rd),
    .mv_data_i   (mv_data),
    .result      (result_bus),
    .we_o        (we),
    .waddr_o     (waddr),
    .wdata_o     (wdata),
    .rsp_valid_o (rsp_valid),
    .rsp_ready_i (rsp_ready),
    .rsp_o       (rsp)
  );

  fp_spill_reg #(.T(fp_ss_pkg::acc_rsp_t)) rsp_spill_i (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .valid_i  (rsp_valid),
    .ready_o  (rsp_ready),
    .data_i   (rsp),
    .valid_o  (acc_pvalid_o),
    .ready_i  (acc_pready_i),
    .data_o   (rsp_q)
  );

endmodule

`default_nettype wire

// File: src/fp_writeback.sv
/* Writeback
   Shares the register write port between moves and pipe results and
   turns bus-bound results into responses */
`timescale 1ns/1ps
`default_nettype none

module fp_writeback (
  input  logic                          mv_valid_i,
  input  logic [fp_ss_pkg::REG_AW-1:0]  mv_rd_i,
  input  logic [fp_ss_pkg::FLEN-1:0]    mv_data_i,
  fp_result_if.slave                    result,
  output logic                          we_o,
  output logic [fp_ss_pkg::REG_AW-1:0]  waddr_o,
  output logic [fp_ss_pkg::FLEN-1:0]    wdata_o,
  output logic                          rsp_valid_o,
  input  logic                          rsp_ready_i,
  output fp_ss_pkg::acc_rsp_t           rsp_o
);

  // Move has the write port first, a pipe result waits a cycle
  always_comb begin
    if (mv_valid_i) begin
      we_o    = 1'b1;
      waddr_o = mv_rd_i;
      wdata_o = mv_data_i;
    end else begin
      we_o    = result.valid && !result.tag.to_bus;
      waddr_o = result.tag.rd;
      wdata_o = result.data;
    end
  end

  assign rsp_valid_o = result.valid && result.tag.to_bus;
  assign rsp_o       = '{id: result.tag.id, data: result.data, error: result.tag.error};

  // Ready comes from the sink the tag selects
  assign result.ready = result.tag.to_bus ? rsp_ready_i : !mv_valid_i;

endmodule

`default_nettype wire
